/* common/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

    localparam int XLEN      = 32;
    localparam int ROB_DEPTH = 7;
    localparam int RS_DEPTH  = 4;
    localparam int NUM_REGS  = 32;

    // rv32i major opcodes
    localparam logic [6:0] OPC_ALU_R  = 7'b0110011;
    localparam logic [6:0] OPC_ALU_I  = 7'b0010011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [2:0]      rob_tag_t;
    typedef logic [4:0]      reg_idx_t;

    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
        OP_BEQ, OP_BNE, OP_BLT, OP_STA
    } alu_op_e;

    typedef enum logic [1:0] {CLS_ALU, CLS_STORE, CLS_BRANCH} inst_class_e;

    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        rob_tag_t tag;
        word_t    src1_val;
        rob_tag_t src1_tag;
        word_t    src2_val;
        rob_tag_t src2_tag;
        word_t    imm;
        logic     use_imm;
        word_t    pc;
    } issue_pkt_t;

    typedef struct packed {
        logic        valid;
        inst_class_e cls;
        reg_idx_t    rd;
        word_t       pc;
        logic        predicted_taken;
    } rob_alloc_t;

    // value is alu result, store address or resolved next pc
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
        word_t    aux;
        logic     taken;
    } cdb_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    value;
    } commit_t;

    typedef struct packed {
        logic  valid;
        word_t addr;
        word_t data;
    } store_t;

    typedef struct packed {
        logic  valid;
        logic  misbranch;
        logic  taken;
        word_t target;
    } branch_t;

endpackage

`default_nettype wire

/* hw/decode/issue_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module issue_decode
    import ooo_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       inst_valid,
    input  word_t      inst,
    input  word_t      pc,
    input  logic       predicted_taken,
    input  logic       rob_full,
    input  logic       rs_full,
    input  logic       flush_pending,
    input  rob_tag_t   alloc_tag,
    input  rob_tag_t   rf_tag1,
    input  rob_tag_t   rf_tag2,
    input  word_t      rf_val1,
    input  word_t      rf_val2,
    input  logic       rob_ready1,
    input  logic       rob_ready2,
    input  word_t      rob_val1,
    input  word_t      rob_val2,
    input  cdb_t       cdb,
    output logic       accept,
    output reg_idx_t   rs1,
    output reg_idx_t   rs2,
    output rob_tag_t   query_tag1,
    output rob_tag_t   query_tag2,
    output rob_alloc_t rob_alloc,
    output reg_idx_t   rename_rd,
    output issue_pkt_t issue
);
    inst_class_e cls;
    alu_op_e     op;
    word_t       imm;
    reg_idx_t    rd;
    logic        legal, use_imm, uses_rs2, take, redirect_q;

    function automatic logic waiting(rob_tag_t t, logic rdy, cdb_t c);
        return t != '0 && !rdy && !(c.valid && c.tag == t);
    endfunction

    // tag 0 reads the register file, else the rob, else the bus
    function automatic word_t operand(rob_tag_t t, word_t rf_v, logic rdy, word_t rob_v,
                                      cdb_t c);
        if (t == '0)
            return rf_v;
        if (rdy)
            return rob_v;
        return c.value;
    endfunction

    always_comb begin
        legal    = 1'b1;
        cls      = CLS_ALU;
        op       = OP_ADD;
        use_imm  = 1'b1;
        uses_rs2 = 1'b0;
        rd       = inst[11:7];
        imm      = {{20{inst[31]}}, inst[31:20]};
        case (inst[6:0])
            OPC_ALU_R: begin
                use_imm  = 1'b0;
                uses_rs2 = 1'b1;
                case (inst[14:12])
                    3'b000:  op = inst[30] ? OP_SUB : OP_ADD;
                    3'b010:  op = OP_SLT;
                    3'b100:  op = OP_XOR;
                    3'b110:  op = OP_OR;
                    3'b111:  op = OP_AND;
                    default: legal = 1'b0;
                endcase
                if (inst[31:25] != 7'b0 && !(inst[31:25] == 7'b0100000 && inst[14:12] == 3'b000))
                    legal = 1'b0;
            end
            OPC_ALU_I: begin
                case (inst[14:12])
                    3'b000:  op = OP_ADD;
                    3'b100:  op = OP_XOR;
                    3'b110:  op = OP_OR;
                    3'b111:  op = OP_AND;
                    default: legal = 1'b0;
                endcase
            end
            OPC_STORE: begin
                cls      = CLS_STORE;
                op       = OP_STA;
                uses_rs2 = 1'b1;
                rd       = '0;
                imm      = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                legal    = inst[14:12] == 3'b010;
            end
            OPC_BRANCH: begin
                cls      = CLS_BRANCH;
                use_imm  = 1'b0;
                uses_rs2 = 1'b1;
                rd       = '0;
                imm      = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                case (inst[14:12])
                    3'b000:  op = OP_BEQ;
                    3'b001:  op = OP_BNE;
                    3'b100:  op = OP_BLT;
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
        // anything else becomes addi x0,x0,0
        if (!legal) begin
            cls      = CLS_ALU;
            op       = OP_ADD;
            use_imm  = 1'b1;
            uses_rs2 = 1'b0;
            rd       = '0;
            imm      = '0;
        end
    end

    assign rs1        = legal ? inst[19:15] : '0;
    assign rs2        = uses_rs2 ? inst[24:20] : '0;
    assign query_tag1 = rf_tag1;
    assign query_tag2 = rf_tag2;

    // the front end lands on the corrected pc one cycle after a flush
    always_ff @(posedge clk) begin
        if (rst) begin
            redirect_q <= 1'b0;
        end else begin
            redirect_q <= flush_pending;
        end
    end

    assign accept = !rob_full && !rs_full && !flush_pending && !redirect_q;
    assign take   = inst_valid && accept;

    assign rob_alloc = '{valid: take, cls: cls, rd: rd, pc: pc, predicted_taken: predicted_taken};
    assign rename_rd = rd;

    always_comb begin
        issue.valid    = take;
        issue.op       = op;
        issue.tag      = alloc_tag;
        issue.src1_tag = waiting(rf_tag1, rob_ready1, cdb) ? rf_tag1 : '0;
        issue.src1_val = operand(rf_tag1, rf_val1, rob_ready1, rob_val1, cdb);
        issue.src2_tag = waiting(rf_tag2, rob_ready2, cdb) ? rf_tag2 : '0;
        issue.src2_val = operand(rf_tag2, rf_val2, rob_ready2, rob_val2, cdb);
        issue.imm      = imm;
        issue.use_imm  = use_imm;
        issue.pc       = pc;
    end

endmodule

`default_nettype wire

/* hw/decode/rename_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module rename_regfile
    import ooo_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rename_rd,
    input  rob_tag_t rename_tag,
    input  logic     rename_en,
    input  commit_t  commit,
    input  rob_tag_t commit_tag,
    output rob_tag_t tag1,
    output rob_tag_t tag2,
    output word_t    val1,
    output word_t    val2
);
    word_t    regs [NUM_REGS];
    rob_tag_t tags [NUM_REGS];
    logic     hit1, hit2;

    // retiring value is visible before it lands, since its rob slot may be reused
    assign hit1 = commit.valid && commit.rd == rs1 && tags[rs1] == commit_tag;
    assign hit2 = commit.valid && commit.rd == rs2 && tags[rs2] == commit_tag;

    assign tag1 = hit1 ? '0 : tags[rs1];
    assign val1 = hit1 ? commit.value : regs[rs1];
    assign tag2 = hit2 ? '0 : tags[rs2];
    assign val2 = hit2 ? commit.value : regs[rs2];

    // x0 is never written and never renamed
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            if (commit.valid && commit.rd != '0) begin
                regs[commit.rd] <= commit.value;
                if (tags[commit.rd] == commit_tag)
                    tags[commit.rd] <= '0;
            end
            if (rename_en && rename_rd != '0)
                tags[rename_rd] <= rename_tag;
            if (flush) begin
                for (int i = 0; i < NUM_REGS; i++)
                    tags[i] <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/execute/reservation_station.sv */
`timescale 1ns/100ps
`default_nettype none

module reservation_station
    import ooo_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  issue_pkt_t issue,
    input  cdb_t       cdb,
    output logic       full,
    output issue_pkt_t dispatch
);
    // entries kept in age order, slot 0 is oldest
    issue_pkt_t ent [RS_DEPTH];
    issue_pkt_t cur [RS_DEPTH];
    issue_pkt_t nxt [RS_DEPTH];
    logic [$clog2(RS_DEPTH)-1:0] sel;
    logic found;

    function automatic issue_pkt_t snoop(issue_pkt_t p, cdb_t c);
        issue_pkt_t q;
        q = p;
        if (c.valid && p.src1_tag == c.tag) begin
            q.src1_val = c.value;
            q.src1_tag = '0;
        end
        if (c.valid && p.src2_tag == c.tag) begin
            q.src2_val = c.value;
            q.src2_tag = '0;
        end
        return q;
    endfunction

    // scan from the youngest so the oldest ready entry wins
    always_comb begin
        found = 1'b0;
        sel   = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            cur[i] = snoop(ent[i], cdb);
            if (cur[i].valid && cur[i].src1_tag == '0 && cur[i].src2_tag == '0) begin
                found = 1'b1;
                sel   = i[$clog2(RS_DEPTH)-1:0];
            end
        end
    end

    // compact around the dispatched entry, new work goes behind
    always_comb begin
        int k;
        k = 0;
        for (int i = 0; i < RS_DEPTH; i++)
            nxt[i] = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (cur[i].valid && !(found && sel == i)) begin
                nxt[k] = cur[i];
                k++;
            end
        end
        if (issue.valid && k < RS_DEPTH)
            nxt[k] = issue;
    end

    assign full = ent[RS_DEPTH-1].valid;

    always_ff @(posedge clk) begin
        dispatch <= cur[sel];
        if (rst || flush) begin
            dispatch.valid <= 1'b0;
            for (int i = 0; i < RS_DEPTH; i++)
                ent[i].valid <= 1'b0;
        end else begin
            dispatch.valid <= found;
            for (int i = 0; i < RS_DEPTH; i++)
                ent[i] <= nxt[i];
        end
    end

endmodule

`default_nettype wire

/* hw/execute/alu_pipe.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_pipe
    import ooo_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  issue_pkt_t dispatch,
    output cdb_t       cdb
);
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        logic     is_branch;
        logic     cond;
        word_t    res;
        word_t    aux;
        word_t    target;
        word_t    link;
    } stage_t;

    stage_t s1;
    word_t  opa, opb, res;
    logic   cond;

    assign opa = dispatch.src1_val;
    assign opb = dispatch.use_imm ? dispatch.imm : dispatch.src2_val;

    always_comb begin
        res  = '0;
        cond = 1'b0;
        case (dispatch.op)
            OP_ADD, OP_STA: res = opa + opb;
            OP_SUB:  res = opa - opb;
            OP_AND:  res = opa & opb;
            OP_OR:   res = opa | opb;
            OP_XOR:  res = opa ^ opb;
            OP_SLT:  res = word_t'($signed(opa) < $signed(opb));
            OP_BEQ:  cond = opa == opb;
            OP_BNE:  cond = opa != opb;
            OP_BLT:  cond = $signed(opa) < $signed(opb);
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        s1.tag       <= dispatch.tag;
        s1.is_branch <= dispatch.op inside {OP_BEQ, OP_BNE, OP_BLT};
        s1.cond      <= cond;
        s1.res       <= res;
        s1.aux       <= dispatch.src2_val;
        s1.target    <= dispatch.pc + dispatch.imm;
        s1.link      <= dispatch.pc + 32'd4;
        // stage 2, branches report the pc they really continue at
        cdb.tag   <= s1.tag;
        cdb.aux   <= s1.aux;
        cdb.taken <= s1.is_branch && s1.cond;
        cdb.value <= !s1.is_branch ? s1.res : (s1.cond ? s1.target : s1.link);
        if (rst || flush) begin
            s1.valid  <= 1'b0;
            cdb.valid <= 1'b0;
        end else begin
            s1.valid  <= dispatch.valid;
            cdb.valid <= s1.valid;
        end
    end

endmodule

`default_nettype wire

/* hw/result/reorder_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer
    import ooo_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  rob_alloc_t rob_alloc,
    input  rob_tag_t   query_tag1,
    input  rob_tag_t   query_tag2,
    input  cdb_t       cdb,
    output rob_tag_t   alloc_tag,
    output logic       full,
    output logic       flush_pending,
    output logic       ready1,
    output logic       ready2,
    output word_t      val1,
    output word_t      val2,
    output logic       flush,
    output commit_t    commit,
    output rob_tag_t   commit_tag,
    output store_t     store,
    output branch_t    branch
);
    // slot 0 stays unused so tag 0 never reads as ready
    rob_tag_t           head, tail;
    logic               empty;
    logic [ROB_DEPTH:0] ready_q, taken_q, pred_q;
    word_t              value_q [ROB_DEPTH+1];
    word_t              aux_q   [ROB_DEPTH+1];
    inst_class_e        cls_q   [ROB_DEPTH+1];
    reg_idx_t           rd_q    [ROB_DEPTH+1];
    logic               retire, misbranch;

    function automatic rob_tag_t wrap_inc(rob_tag_t t);
        return (t == rob_tag_t'(ROB_DEPTH)) ? rob_tag_t'(1) : t + rob_tag_t'(1);
    endfunction

    assign alloc_tag = tail;
    assign full      = !empty && head == tail;
    assign ready1    = ready_q[query_tag1];
    assign val1      = value_q[query_tag1];
    assign ready2    = ready_q[query_tag2];
    assign val2      = value_q[query_tag2];

    assign retire    = !empty && ready_q[head];
    assign misbranch = retire && cls_q[head] == CLS_BRANCH && taken_q[head] != pred_q[head];

    // decode sees the flush coming, the other blocks act on it at the same edge
    assign flush_pending = misbranch;
    assign flush         = misbranch;

    always_ff @(posedge clk) begin
        if (rst) begin
            head         <= rob_tag_t'(1);
            tail         <= rob_tag_t'(1);
            empty        <= 1'b1;
            ready_q      <= '0;
            commit.valid <= 1'b0;
            store.valid  <= 1'b0;
            branch.valid <= 1'b0;
        end else begin
            commit.valid <= retire && cls_q[head] == CLS_ALU;
            store.valid  <= retire && cls_q[head] == CLS_STORE;
            branch.valid <= retire && cls_q[head] == CLS_BRANCH;
            if (misbranch) begin
                head    <= rob_tag_t'(1);
                tail    <= rob_tag_t'(1);
                empty   <= 1'b1;
                ready_q <= '0;
            end else begin
                if (rob_alloc.valid) begin
                    ready_q[tail] <= 1'b0;
                    tail          <= wrap_inc(tail);
                end
                if (cdb.valid)
                    ready_q[cdb.tag] <= 1'b1;
                if (retire)
                    head <= wrap_inc(head);
                if (rob_alloc.valid)
                    empty <= 1'b0;
                else if (retire && wrap_inc(head) == tail)
                    empty <= 1'b1;
            end
        end
        if (rob_alloc.valid) begin
            cls_q[tail]  <= rob_alloc.cls;
            rd_q[tail]   <= rob_alloc.rd;
            pred_q[tail] <= rob_alloc.predicted_taken;
        end
        if (cdb.valid) begin
            value_q[cdb.tag] <= cdb.value;
            aux_q[cdb.tag]   <= cdb.aux;
            taken_q[cdb.tag] <= cdb.taken;
        end
        commit.rd        <= rd_q[head];
        commit.value     <= value_q[head];
        commit_tag       <= head;
        store.addr       <= value_q[head];
        store.data       <= aux_q[head];
        branch.misbranch <= misbranch;
        branch.taken     <= taken_q[head];
        branch.target    <= value_q[head];
    end

endmodule

`default_nettype wire

/* hw/ooo_core_top.sv */
`timescale 1ns/100ps
`default_nettype none

module ooo_core_top
    import ooo_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    inst_valid,
    input  word_t   inst,
    input  word_t   pc,
    input  logic    predicted_taken,
    output logic    accept,
    output commit_t commit,
    output store_t  store,
    output branch_t branch
);
    reg_idx_t   rs1, rs2, rename_rd;
    rob_tag_t   query_tag1, query_tag2, alloc_tag, rf_tag1, rf_tag2, commit_tag;
    word_t      rf_val1, rf_val2, rob_val1, rob_val2;
    logic       rob_full, rs_full, flush_pending, flush, rob_ready1, rob_ready2;
    rob_alloc_t rob_alloc;
    issue_pkt_t issue, dispatch;
    cdb_t       cdb;

    issue_decode u_decode (
        .clk, .rst, .inst_valid, .inst, .pc, .predicted_taken,
        .rob_full, .rs_full, .flush_pending, .alloc_tag,
        .rf_tag1, .rf_tag2, .rf_val1, .rf_val2,
        .rob_ready1, .rob_ready2, .rob_val1, .rob_val2, .cdb,
        .accept, .rs1, .rs2, .query_tag1, .query_tag2,
        .rob_alloc, .rename_rd, .issue
    );

    rename_regfile u_regfile (
        .clk, .rst, .flush, .rs1, .rs2, .rename_rd,
        .rename_tag (alloc_tag),
        .rename_en  (rob_alloc.valid),
        .commit, .commit_tag,
        .tag1 (rf_tag1),
        .tag2 (rf_tag2),
        .val1 (rf_val1),
        .val2 (rf_val2)
    );

    reservation_station u_rs (
        .clk, .rst, .flush, .issue, .cdb,
        .full (rs_full),
        .dispatch
    );

    alu_pipe u_alu (
        .clk, .rst, .flush, .dispatch, .cdb
    );

    reorder_buffer u_rob (
        .clk, .rst, .rob_alloc, .query_tag1, .query_tag2, .cdb,
        .alloc_tag,
        .full   (rob_full),
        .flush_pending,
        .ready1 (rob_ready1),
        .ready2 (rob_ready2),
        .val1   (rob_val1),
        .val2   (rob_val2),
        .flush, .commit, .commit_tag, .store, .branch
    );

endmodule

`default_nettype wire

/* test/ooo_core_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module ooo_core_asserts
    import ooo_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input rob_alloc_t rob_alloc,
    input logic       full,
    input cdb_t       cdb,
    input logic       flush,
    input commit_t    commit
);

    no_alloc_when_full: assert property (@(posedge clk) disable iff (rst)
        !(rob_alloc.valid && full))
        else $error("rob allocation while the buffer is full");

    // tag 0 means no tag
    no_cdb_tag_zero: assert property (@(posedge clk) disable iff (rst)
        cdb.valid |-> cdb.tag != '0)
        else $error("cdb item carries tag 0");

    // buffer is empty once the branch pulse is out
    no_commit_after_flush: assert property (@(posedge clk) disable iff (rst)
        $past(flush, 2) |-> !commit.valid)
        else $error("register commit in the cycle after the flushing branch pulse");

endmodule

bind reorder_buffer ooo_core_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .rob_alloc (rob_alloc),
    .full      (full),
    .cdb       (cdb),
    .flush     (flush),
    .commit    (commit)
);

`default_nettype wire

/* test/ooo_scoreboard.sv */
`timescale 1ns/100ps
`default_nettype none

module ooo_scoreboard
    import ooo_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    inst_valid,
    input word_t   inst,
    input word_t   pc,
    input logic    predicted_taken,
    input logic    accept,
    input commit_t commit,
    input store_t  store,
    input branch_t branch
);
    word_t inst_q [$];
    word_t pc_q   [$];
    logic  pred_q [$];
    word_t regs   [NUM_REGS];
    int    pushed = 0;
    int    pulses = 0;
    int    dropped = 0;
    int    errors = 0;
    int    depth = 0;
    string test_name = "none";

    initial begin
        for (int i = 0; i < NUM_REGS; i++)
            regs[i] = '0;
    end

    task automatic check_word(string what, word_t exp, word_t act);
        if (exp !== act) begin
            $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic wrong_pulse(string want, word_t ipc);
        $display("[%s] instruction at pc %h should retire as a %s but another pulse came",
                 test_name, ipc, want);
        errors++;
    endtask

    // executes the oldest instruction on the register model
    task automatic retire_one();
        word_t    ins, ipc, a, b, res, imm, target;
        logic     pred, taken;
        reg_idx_t rd;
        ins   = inst_q.pop_front();
        ipc   = pc_q.pop_front();
        pred  = pred_q.pop_front();
        a     = regs[ins[19:15]];
        b     = regs[ins[24:20]];
        rd    = ins[11:7];
        res   = '0;
        taken = 1'b0;
        case (ins[6:0])
            7'b0110011, 7'b0010011: begin
                if (!ins[5])
                    b = {{20{ins[31]}}, ins[31:20]};
                case (ins[14:12])
                    3'b000:  res = (ins[5] && ins[30]) ? a - b : a + b;
                    3'b010:  res = word_t'($signed(a) < $signed(b));
                    3'b100:  res = a ^ b;
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
                if (!commit.valid) begin
                    wrong_pulse("register commit", ipc);
                end else begin
                    check_word("commit rd", word_t'(rd), word_t'(commit.rd));
                    check_word("commit value", res, commit.value);
                end
                if (rd != '0)
                    regs[rd] = res;
            end
            7'b0100011: begin
                imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                if (!store.valid) begin
                    wrong_pulse("store", ipc);
                end else begin
                    check_word("store addr", a + imm, store.addr);
                    check_word("store data", b, store.data);
                end
            end
            default: begin
                imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                case (ins[14:12])
                    3'b000:  taken = a == b;
                    3'b001:  taken = a != b;
                    default: taken = $signed(a) < $signed(b);
                endcase
                target = taken ? ipc + imm : ipc + 32'd4;
                if (!branch.valid) begin
                    wrong_pulse("branch resolve", ipc);
                end else begin
                    check_word("branch taken", word_t'(taken), word_t'(branch.taken));
                    check_word("branch misbranch", word_t'(taken != pred),
                               word_t'(branch.misbranch));
                    check_word("branch target", target, branch.target);
                end
                // younger work was flushed
                if (taken != pred) begin
                    dropped += inst_q.size();
                    inst_q.delete();
                    pc_q.delete();
                    pred_q.delete();
                end
            end
        endcase
    endtask

    // inputs and registered outputs are both stable just after the falling edge
    always @(negedge clk) begin
        #1;
        if (!rst) begin
            if (commit.valid || store.valid || branch.valid) begin
                pulses += int'(commit.valid) + int'(store.valid) + int'(branch.valid);
                if (int'(commit.valid) + int'(store.valid) + int'(branch.valid) > 1) begin
                    $display("[%s] more than one retire pulse in a single cycle", test_name);
                    errors++;
                end
                if (inst_q.size() == 0) begin
                    $display("[%s] a retire pulse arrived with no instruction outstanding",
                             test_name);
                    errors++;
                end else begin
                    retire_one();
                end
            end
            if (inst_valid && accept) begin
                // queue now holds exactly what sits in the rob
                if (inst_q.size() >= ROB_DEPTH) begin
                    $display("[%s] an instruction was accepted with %0d already in flight",
                             test_name, inst_q.size());
                    errors++;
                end
                inst_q.push_back(inst);
                pc_q.push_back(pc);
                pred_q.push_back(predicted_taken);
                pushed++;
            end
        end
        depth = inst_q.size();
    end

endmodule

`default_nettype wire

/* test/ooo_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ooo_core_tb
    import ooo_pkg::*;
();
    localparam int N_INST      = 400;
    localparam int CYCLE_LIMIT = 4 * N_INST * 12 + 200;

    logic    clk, rst, inst_valid, predicted_taken, accept;
    word_t   inst, pc;
    commit_t commit;
    store_t  store;
    branch_t branch;

    logic [31:0] lfsr = 32'h9969c0e2;
    int cycles = 0;
    int tb_errors = 0;
    int stall_cycles = 0;
    int tests_run = 0;
    int tests_failed = 0;

    ooo_core_top DUT (
        .clk, .rst, .inst_valid, .inst, .pc, .predicted_taken,
        .accept, .commit, .store, .branch
    );

    ooo_scoreboard sb (
        .clk, .rst, .inst_valid, .inst, .pc, .predicted_taken,
        .accept, .commit, .store, .branch
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic reg_idx_t pick_reg();
        return reg_idx_t'(rand_bits(2) + 1);
    endfunction

    function automatic word_t alu_inst(reg_idx_t rd, reg_idx_t r1, reg_idx_t r2);
        logic [2:0]  sel;
        logic [11:0] imm;
        sel = rand_bits(3);
        imm = rand_bits(12);
        case (sel)
            3'd0:    return {7'h00, r2, r1, 3'b000, rd, 7'b0110011};
            3'd1:    return {7'h20, r2, r1, 3'b000, rd, 7'b0110011};
            3'd2:    return {7'h00, r2, r1, 3'b010, rd, 7'b0110011};
            3'd3:    return {7'h00, r2, r1, 3'b100, rd, 7'b0110011};
            3'd4:    return {7'h00, r2, r1, 3'b110, rd, 7'b0110011};
            3'd5:    return {7'h00, r2, r1, 3'b111, rd, 7'b0110011};
            3'd6:    return {imm, r1, 3'b000, rd, 7'b0010011};
            default: return {imm, r1, 3'b100 | 3'(rand_bits(2) % 3 == 0 ? 0 : 2 +
                             rand_bits(1)), rd, 7'b0010011};
        endcase
    endfunction

    // kind 0 alu chains, 1 stores, 2 branches, 3 backpressure
    task automatic new_inst(int kind);
        logic [11:0] simm;
        logic [12:0] bimm;
        logic [4:0]  off;
        logic [2:0]  f3;
        predicted_taken = 1'b0;
        if (kind == 1 && rand_bits(1) == 1) begin
            simm = rand_bits(12);
            inst = {simm[11:5], pick_reg(), pick_reg(), 3'b010, simm[4:0], 7'b0100011};
        end else if (kind == 2 && rand_bits(2) == 0) begin
            off  = rand_bits(5);
            bimm = {{6{off[4]}}, off, 2'b00};
            f3   = rand_bits(2) % 3 == 0 ? 3'b000 : (rand_bits(1) == 1 ? 3'b001 : 3'b100);
            inst = {bimm[12], bimm[10:5], pick_reg(), pick_reg(), f3, bimm[4:1], bimm[11],
                    7'b1100011};
            predicted_taken = rand_bits(1);
        end else if (kind == 3) begin
            // everything hangs off x1
            inst = alu_inst(rand_bits(2) == 0 ? reg_idx_t'(2) : reg_idx_t'(1),
                            reg_idx_t'(1), reg_idx_t'(1));
        end else begin
            inst = alu_inst(pick_reg(), pick_reg(), pick_reg());
        end
    endtask

    task automatic report_test(string name, int err0);
        int errs;
        errs = sb.errors + tb_errors - err0;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
            $display("test %-16s failed with %0d errors", name, errs);
        end else begin
            $display("test %-16s ok", name);
        end
    endtask

    task automatic check_reset_state();
        int err0;
        err0 = sb.errors + tb_errors;
        sb.test_name = "reset_state";
        repeat (8) begin
            @(negedge clk);
            #1;
            if (!accept) begin
                $display("[reset_state] accept is low after reset");
                tb_errors++;
            end
            if (commit.valid || store.valid || branch.valid) begin
                $display("[reset_state] a retire pulse appeared before any instruction");
                tb_errors++;
            end
        end
        report_test("reset_state", err0);
    endtask

    task automatic run_test(string name, int kind);
        int   err0, push0, drop0, pulse0, stall0, issued;
        logic took, fresh;
        sb.test_name = name;
        err0   = sb.errors + tb_errors;
        push0  = sb.pushed;
        drop0  = sb.dropped;
        pulse0 = sb.pulses;
        stall0 = stall_cycles;
        issued = 0;
        took   = 1'b0;
        fresh  = 1'b1;
        while (issued < N_INST) begin
            @(negedge clk);
            if (branch.valid && branch.misbranch) begin
                pc    = branch.target;
                fresh = 1'b1;
            end else if (took) begin
                pc    = pc + 32'd4;
                fresh = 1'b1;
            end
            if (fresh)
                new_inst(kind);
            fresh      = 1'b0;
            inst_valid = (kind == 3) || rand_bits(2) != 0;
            #1;
            took = inst_valid && accept;
            if (inst_valid && !accept)
                stall_cycles++;
            if (took)
                issued++;
        end
        @(negedge clk);
        if (branch.valid && branch.misbranch)
            pc = branch.target;
        else
            pc = pc + 32'd4;
        inst_valid = 1'b0;
        #2;
        while (sb.depth != 0) begin
            @(negedge clk);
            if (branch.valid && branch.misbranch)
                pc = branch.target;
            #2;
        end
        if (kind == 3 && stall_cycles == stall0) begin
            $display("[%s] accept never dropped while inst_valid was held high", name);
            tb_errors++;
        end
        if (sb.pulses - pulse0 != (sb.pushed - push0) - (sb.dropped - drop0)) begin
            $display("** Error [%s] retire count: expected %0d, actual %0d", name,
                     (sb.pushed - push0) - (sb.dropped - drop0), sb.pulses - pulse0);
            tb_errors++;
        end
        report_test(name, err0);
    endtask

    initial begin
        rst             = 1'b1;
        inst_valid      = 1'b0;
        inst            = '0;
        pc              = 32'h0000_1000;
        predicted_taken = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_reset_state();
        run_test("alu_chains", 0);
        run_test("store_stream", 1);
        run_test("branch_mix", 2);
        run_test("rob_backpressure", 3);

        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors", tests_run,
                 tests_run - tests_failed, tests_failed, sb.errors + tb_errors);
        if (tests_failed == 0 && sb.errors + tb_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
common/ooo_pkg.sv
hw/decode/issue_decode.sv
hw/decode/rename_regfile.sv
hw/execute/reservation_station.sv
hw/execute/alu_pipe.sv
hw/result/reorder_buffer.sv
hw/ooo_core_top.sv
test/ooo_core_asserts.sv
test/ooo_scoreboard.sv
test/ooo_core_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module ooo_core_tb \
    -f compile.f \
    -o ooo_core_sim

./obj_dir/ooo_core_sim > sim.log
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0
